// File: nn_pkg.sv
package nn_pkg;

    localparam int DATA_W     = 16; // q8.8 data word
    localparam int FRAC_W     = 8;  // fractional bits of a data word
    localparam int ACC_W      = 40; // wide enough for many q16.16 products
    localparam int INSTR_W    = 25;
    localparam int ADDR_W     = 4;
    localparam int LEAK_SHIFT = 2;  // negative slope of 1/4

    typedef enum logic [2:0] {
        OP_NOP         = 3'd0,
        OP_LOAD_INPUT  = 3'd1, // addr selects the input lane
        OP_LOAD_WEIGHT = 3'd2, // addr is row * LANES + column
        OP_LOAD_BIAS   = 3'd3, // addr selects the output lane
        OP_RUN         = 3'd4
    } opcode_e;

    typedef logic signed [DATA_W-1:0] data_t;

    // instruction word layout, msb first
    typedef struct packed {
        opcode_e           opcode; // 24:22
        logic              route;  // 21, 1 sends results back to the inputs
        logic              spare;  // 20
        logic [ADDR_W-1:0] addr;   // 19:16
        data_t             data;   // 15:0
    } instr_t;

endpackage

// File: stage_if.sv
// one lane's operand stream, one beat per cycle while valid is high
interface stage_if;

    nn_pkg::data_t x;     // activation shared by all lanes on this beat
    nn_pkg::data_t w;     // weight for this lane's column
    nn_pkg::data_t bias;  // held for the whole stream
    logic          first; // restart the accumulator
    logic          last;  // finish and register the result
    logic          valid;

    modport stager (
        output x,
        output w,
        output bias,
        output first,
        output last,
        output valid
    );

    modport lane (
        input x,
        input w,
        input bias,
        input first,
        input last,
        input valid
    );

endinterface

// File: control_unit.sv
module control_unit (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [nn_pkg::INSTR_W-1:0] instruction,
    output logic                       ld_input,
    output logic                       ld_weight,
    output logic                       ld_bias,
    output logic [nn_pkg::ADDR_W-1:0]  addr,
    output nn_pkg::data_t              wdata,
    output logic                       run,
    output logic                       route,
    output logic                       busy,
    input  logic                       done
);

    nn_pkg::instr_t instr;
    logic           accept;   // engine idle, instruction is taken
    logic           is_run;

    assign instr  = nn_pkg::instr_t'(instruction);
    assign accept = ~busy;
    assign is_run = accept && (instr.opcode == nn_pkg::OP_RUN);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_input  <= 1'b0;
            ld_weight <= 1'b0;
            ld_bias   <= 1'b0;
            addr      <= '0;
            wdata     <= '0;
            run       <= 1'b0;
            route     <= 1'b0;
            busy      <= 1'b0;
        end else begin
            // strobes last one cycle
            ld_input  <= accept && (instr.opcode == nn_pkg::OP_LOAD_INPUT);
            ld_weight <= accept && (instr.opcode == nn_pkg::OP_LOAD_WEIGHT);
            ld_bias   <= accept && (instr.opcode == nn_pkg::OP_LOAD_BIAS);
            run       <= is_run;

            if (accept) begin
                addr  <= instr.addr;
                wdata <= instr.data;
            end

            if (is_run) begin
                route <= instr.route; // held until the next run
            end

            // busy spans the whole run, the result collector ends it
            if (is_run) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: operand_stager.sv
module operand_stager #(
    parameter int LANES = 2
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          ld_input,
    input  logic                          ld_weight,
    input  logic                          ld_bias,
    input  logic [nn_pkg::ADDR_W-1:0]     addr,
    input  nn_pkg::data_t                 wdata,
    input  logic                          run,
    input  nn_pkg::data_t [LANES-1:0]     fb_data,
    input  logic                          fb_we,
    stage_if.stager                       lanes [LANES]
);

    localparam int CNT_W = (LANES > 1) ? $clog2(LANES) : 1;

    nn_pkg::data_t [LANES-1:0]       x_mem; // input vector
    nn_pkg::data_t [LANES*LANES-1:0] w_mem; // row major, row = input index
    nn_pkg::data_t [LANES-1:0]       b_mem; // one bias per output lane

    logic [CNT_W-1:0] cnt;        // index of the next beat
    logic             active;     // stream past its first beat
    logic [CNT_W-1:0] idx;        // index of the current beat
    logic             beat_valid;
    logic             first_beat;
    logic             last_beat;

    // first beat goes out in the same cycle as the run pulse
    assign idx        = active ? cnt : '0;
    assign beat_valid = run | active;
    assign first_beat = beat_valid && (idx == '0);
    assign last_beat  = beat_valid && (int'(idx) == LANES - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (beat_valid) begin
            if (last_beat) begin
                cnt    <= '0;
                active <= 1'b0;
            end else begin
                cnt    <= idx + 1'b1;
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_mem <= '0;
            w_mem <= '0;
            b_mem <= '0;
        end else begin
            if (fb_we) begin
                x_mem <= fb_data; // previous layer becomes the next input
            end else if (ld_input && int'(addr) < LANES) begin
                x_mem[addr] <= wdata;
            end

            if (ld_weight && int'(addr) < LANES * LANES) begin
                w_mem[addr] <= wdata;
            end

            if (ld_bias && int'(addr) < LANES) begin
                b_mem[addr] <= wdata;
            end
        end
    end

    // every lane sees the same input, each with its own column weight
    for (genvar j = 0; j < LANES; j++) begin : g_lane
        assign lanes[j].valid = beat_valid;
        assign lanes[j].first = first_beat;
        assign lanes[j].last  = last_beat;
        assign lanes[j].x     = x_mem[idx];
        assign lanes[j].w     = w_mem[int'(idx) * LANES + j];
        assign lanes[j].bias  = b_mem[j];
    end

endmodule

// File: pe_lane.sv
module pe_lane #(
    parameter int LEAK_SHIFT = nn_pkg::LEAK_SHIFT
) (
    input  logic          clk,
    input  logic          arst_n,
    stage_if.lane         op,
    output nn_pkg::data_t res_data,
    output logic          res_valid
);

    localparam int DATA_W = nn_pkg::DATA_W;
    localparam int FRAC_W = nn_pkg::FRAC_W;
    localparam int ACC_W  = nn_pkg::ACC_W;
    localparam int PROD_W = 2 * DATA_W;

    logic signed [PROD_W-1:0] prod;     // q16.16
    logic signed [ACC_W-1:0]  prod_ext;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  acc_sum;
    logic signed [ACC_W-1:0]  bias_ext; // bias aligned to the product scale
    logic signed [ACC_W-1:0]  biased;
    logic signed [ACC_W-1:0]  shifted;
    logic                     fits;     // shifted value fits in a data word
    nn_pkg::data_t            sat;
    nn_pkg::data_t            act;

    assign prod     = op.x * op.w;
    assign prod_ext = {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
    assign acc_sum  = op.first ? prod_ext : acc + prod_ext;

    assign bias_ext = {{(ACC_W - DATA_W - FRAC_W){op.bias[DATA_W-1]}}, op.bias,
                       {FRAC_W{1'b0}}};
    assign biased   = acc_sum + bias_ext;
    assign shifted  = biased >>> FRAC_W; // rounds toward minus infinity

    // all bits above the data word must repeat its sign bit
    assign fits = (shifted[ACC_W-1:DATA_W-1] == {(ACC_W - DATA_W + 1){shifted[ACC_W-1]}});

    always_comb begin
        if (fits) begin
            sat = shifted[DATA_W-1:0];
        end else if (shifted[ACC_W-1]) begin
            sat = {1'b1, {(DATA_W - 1){1'b0}}}; // most negative
        end else begin
            sat = {1'b0, {(DATA_W - 1){1'b1}}}; // most positive
        end
    end

    assign act = sat[DATA_W-1] ? (sat >>> LEAK_SHIFT) : sat; // leaky relu

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc       <= '0;
            res_data  <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= op.valid & op.last;
            if (op.valid) begin
                acc <= acc_sum;
            end
            if (op.valid && op.last) begin
                res_data <= act;
            end
        end
    end

endmodule

// File: result_collector.sv
module result_collector #(
    parameter int LANES = 2
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  nn_pkg::data_t [LANES-1:0]      res_data,
    input  logic [LANES-1:0]               res_valid,
    input  logic                           route,
    output logic [LANES*nn_pkg::DATA_W-1:0] data_out,
    output logic                           valid_out,
    output nn_pkg::data_t [LANES-1:0]      fb_data,
    output logic                           fb_we,
    output logic                           done
);

    nn_pkg::data_t [LANES-1:0] out_q; // last result sent to the outputs
    logic                      take;  // lanes run in step, lane 0 stands for all

    assign take     = res_valid[0];
    assign data_out = out_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q     <= '0;
            fb_data   <= '0;
            valid_out <= 1'b0;
            fb_we     <= 1'b0;
            done      <= 1'b0;
        end else begin
            valid_out <= take & ~route;
            fb_we     <= take & route;
            done      <= take;

            for (int i = 0; i < LANES; i++) begin
                if (res_valid[i]) begin
                    if (route) begin
                        fb_data[i] <= res_data[i]; // outputs keep the old result
                    end else begin
                        out_q[i] <= res_data[i];
                    end
                end
            end
        end
    end

endmodule

// File: nn.sv
module nn #(
    parameter int LANES      = 2,
    parameter int LEAK_SHIFT = nn_pkg::LEAK_SHIFT
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [nn_pkg::INSTR_W-1:0]      instruction,
    output logic [LANES*nn_pkg::DATA_W-1:0] data_out,   // lane 0 in the low word
    output logic                            valid_out,
    output logic                            busy
);

    logic                      ld_input;
    logic                      ld_weight;
    logic                      ld_bias;
    logic [nn_pkg::ADDR_W-1:0] addr;
    nn_pkg::data_t             wdata;
    logic                      run;
    logic                      route;  // 1 feeds the results back as inputs
    logic                      done;

    nn_pkg::data_t [LANES-1:0] fb_data;
    logic                      fb_we;
    nn_pkg::data_t [LANES-1:0] res_data;
    logic [LANES-1:0]          res_valid;

    stage_if stage [LANES] ();

    control_unit control_unit_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .instruction(instruction),
        .ld_input   (ld_input),
        .ld_weight  (ld_weight),
        .ld_bias    (ld_bias),
        .addr       (addr),
        .wdata      (wdata),
        .run        (run),
        .route      (route),
        .busy       (busy),
        .done       (done)
    );

    operand_stager #(.LANES(LANES)) operand_stager_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .ld_input (ld_input),
        .ld_weight(ld_weight),
        .ld_bias  (ld_bias),
        .addr     (addr),
        .wdata    (wdata),
        .run      (run),
        .fb_data  (fb_data),
        .fb_we    (fb_we),
        .lanes    (stage)
    );

    for (genvar j = 0; j < LANES; j++) begin : g_lane
        pe_lane #(.LEAK_SHIFT(LEAK_SHIFT)) pe_lane_inst (
            .clk      (clk),
            .arst_n   (arst_n),
            .op       (stage[j]),
            .res_data (res_data[j]),
            .res_valid(res_valid[j])
        );
    end

    result_collector #(.LANES(LANES)) result_collector_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .res_data (res_data),
        .res_valid(res_valid),
        .route    (route),
        .data_out (data_out),
        .valid_out(valid_out),
        .fb_data  (fb_data),
        .fb_we    (fb_we),
        .done     (done)
    );

endmodule

// File: nn_asserts.sv
module nn_asserts (
    input logic clk,
    input logic arst_n,
    input logic valid_out,
    input logic busy
);

    int fail_count = 0; // read by the testbench at the end of the run

    // a result is announced for exactly one cycle
    valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |=> !valid_out)
    else begin
        fail_count++;
        $error("valid_out stayed high for more than one cycle");
    end

    valid_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |-> busy)
    else begin
        fail_count++;
        $error("valid_out rose while the engine was idle");
    end

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !busy)
    else begin
        fail_count++;
        $error("busy was high while reset was held");
    end

endmodule

bind nn nn_asserts nn_asserts_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .valid_out(valid_out),
    .busy     (busy)
);

// File: tb_nn.sv
module tb_nn;

    localparam int          LANES        = 2;
    localparam int          LEAK_SHIFT   = nn_pkg::LEAK_SHIFT;
    localparam int          OUT_W        = LANES * nn_pkg::DATA_W;
    localparam int          MAX_VEC      = 64;
    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_GAP      = 3;    // longest run of random nops
    localparam logic [31:0] SEED         = 32'hdf0d_7681;

    // run held on the instruction pins while reset is asserted
    localparam logic [nn_pkg::INSTR_W-1:0] RESET_RUN = {nn_pkg::OP_RUN, 22'h0};

    localparam logic [31:0] F_OUTPUT   = 32'h1; // run, one valid_out pulse
    localparam logic [31:0] F_FEEDBACK = 32'h2; // run routed back, no pulse
    localparam logic [31:0] F_BUSY     = 32'h3; // follows a run without waiting
    localparam logic [31:0] F_END      = 32'hf;

    logic                       clk;
    logic                       arst_n;
    logic [nn_pkg::INSTR_W-1:0] instruction;
    logic [OUT_W-1:0]           data_out;
    logic                       valid_out;
    logic                       busy;

    logic [31:0] vec_mem [0:3*MAX_VEC-1]; // three words per line
    int          n_vec;
    int          n_checks = 0;
    int          n_errors = 0;
    int          valid_count = 0;         // valid_out pulses seen so far
    int          timeout_cycles = 0;

    nn #(.LANES(LANES), .LEAK_SHIFT(LEAK_SHIFT)) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .instruction(instruction),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (valid_out) begin
            valid_count <= valid_count + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic drive(input logic [31:0] value);
        @(posedge clk);
        instruction <= value[nn_pkg::INSTR_W-1:0];
    endtask

    // nop in, then wait for the run to start and to finish
    task automatic wait_idle();
        drive(32'h0);
        while (!busy) begin
            @(posedge clk);
        end
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic check_result(input int idx, input int count_at_run);
        string       name;
        logic [31:0] flag;
        logic [31:0] exp_pulses;
        name       = $sformatf("vector %0d", idx);
        flag       = vec_mem[3*idx+1];
        exp_pulses = (flag == F_OUTPUT) ? 32'd1 : 32'd0;
        wait_idle();
        check({name, " valid_out pulses"}, exp_pulses, 32'(valid_count - count_at_run));
        check({name, " data_out"}, vec_mem[3*idx+2], 32'(data_out));
    endtask

    function automatic int count_vectors();
        for (int i = 0; i < MAX_VEC; i++) begin
            if (vec_mem[3*i+1] == F_END) begin
                return i;
            end
        end
        return -1; // no end marker
    endfunction

    task automatic replay_vectors();
        int          pending;      // run still waiting for its check
        int          count_at_run;
        logic [31:0] flag;
        pending      = -1;
        count_at_run = 0;
        for (int i = 0; i < n_vec; i++) begin
            flag = vec_mem[3*i+1];
            if (flag != F_BUSY) begin
                if (pending >= 0) begin
                    check_result(pending, count_at_run);
                    pending = -1;
                end
                repeat ($urandom % (MAX_GAP + 1)) begin
                    drive(32'h0);
                end
            end
            if (flag == F_OUTPUT || flag == F_FEEDBACK) begin
                pending      = i;
                count_at_run = valid_count;
            end
            drive(vec_mem[3*i]);
        end
        if (pending >= 0) begin
            check_result(pending, count_at_run);
        end
        drive(32'h0);
    endtask

    initial begin
        arst_n      = 1'b0;
        instruction = RESET_RUN; // must not start the engine
        void'($urandom(SEED));
        $readmemh("nn_vectors.txt", vec_mem);
        n_vec = count_vectors();
        if (n_vec > 0) begin
            timeout_cycles = n_vec * (LANES + 20) + RESET_CYCLES;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n      <= 1'b1;
        instruction <= '0;

        if (n_vec > 0) begin
            replay_vectors();
        end else begin
            $display("vector file nn_vectors.txt is missing, empty or has no end marker");
            n_errors++;
        end

        n_errors += DUT.nn_asserts_inst.fail_count;
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, sized from the number of vectors
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the engine did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: nn.f
nn_pkg.sv
stage_if.sv
control_unit.sv
operand_stager.sv
pe_lane.sv
result_collector.sv
nn.sv
nn_asserts.sv
tb_nn.sv

// File: Makefile
# Verilator build and run for the nn layer engine

VERILATOR ?= verilator
TOP       ?= tb_nn
FILELIST  ?= nn.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: nn_vectors.txt
// columns: instruction (25 bit), flag, expected data_out {lane1, lane0}
// flag 0 load, 1 run to outputs, 2 run fed back, 3 sent while busy, f end
1000000 1 00000000
// identity weights, zero bias
0800100 0 00000000
0830100 0 00000000
0400180 0 00000000
0410240 0 00000000
1000000 1 02400180
// mixed weights and biases, truncated q8.8 sums
0800081 0 00000000
0810040 0 00000000
082ff00 0 00000000
0830133 0 00000000
0c00200 0 00000000
0c1fff0 0 00000000
1000000 1 03020081
// negative sum through the leak, positive saturation
082f000 0 00000000
0837fff 0 00000000
1000000 1 7ffff7b0
// two chained layers
0800100 0 00000000
0810100 0 00000000
0820000 0 00000000
0830100 0 00000000
0c00000 0 00000000
0c10000 0 00000000
0400100 0 00000000
0410200 0 00000000
1200000 2 7ffff7b0
1000000 1 04000100
// loads during a run are dropped
1000000 1 04000100
0400800 3 00000000
0800000 3 00000000
1000000 1 04000100
0400080 0 00000000
1000000 1 03800080
0000000 f 00000000
